//--- src/xfcp_pkg.sv
package xfcp_pkg;

    // Stream and Wishbone widths
    parameter int byte_w         = 8;
    parameter int wb_addr_w      = 8;
    parameter int wb_data_w      = 32;
    parameter int bytes_per_word = wb_data_w / byte_w;

    // Command and response opcodes
    // A response opcode is its request opcode plus one
    typedef enum logic [7:0] {
        OP_READ       = 8'h10,
        OP_READ_RESP  = 8'h11,
        OP_WRITE      = 8'h12,
        OP_WRITE_RESP = 8'h13
    } opcode_e;

endpackage

//--- src/wb_ram.sv
`timescale 1ns/1ps

module wb_ram (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [xfcp_pkg::wb_addr_w-1:0] adr_i,
    input  logic [xfcp_pkg::wb_data_w-1:0] dat_i,
    output logic [xfcp_pkg::wb_data_w-1:0] dat_o,
    input  logic                           we_i,
    input  logic                           stb_i,
    input  logic                           cyc_i,
    output logic                           ack_o
);

    logic [xfcp_pkg::wb_data_w-1:0] mem [0:(1 << xfcp_pkg::wb_addr_w)-1];
    logic                           access;

    // One access per strobe
    // The ack cycle itself does nothing
    assign access = cyc_i && stb_i && !ack_o;

    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

//--- src/xfcp_mod_wb.sv
`timescale 1ns/1ps

module xfcp_mod_wb (
    input  logic                           clk,
    input  logic                           arst_n_i,

    input  logic [xfcp_pkg::byte_w-1:0]    req_tdata_i,
    input  logic                           req_tvalid_i,
    output logic                           req_tready_o,
    input  logic                           req_tlast_i,

    output logic [xfcp_pkg::byte_w-1:0]    resp_tdata_o,
    output logic                           resp_tvalid_o,
    input  logic                           resp_tready_i,
    output logic                           resp_tlast_o,

    output logic [xfcp_pkg::wb_addr_w-1:0] wb_adr_o,
    output logic [xfcp_pkg::wb_data_w-1:0] wb_dat_o,
    input  logic [xfcp_pkg::wb_data_w-1:0] wb_dat_i,
    output logic                           wb_we_o,
    output logic                           wb_stb_o,
    output logic                           wb_cyc_o,
    input  logic                           wb_ack_i
);

    typedef enum logic [3:0] {
        ST_OP,
        ST_ADDR,
        ST_CNT,
        ST_WDATA,
        ST_WCYC,
        ST_FLUSH,
        ST_HDR,
        ST_RCYC,
        ST_RDATA
    } state_e;

    state_e                                        state_r;
    logic [$clog2(xfcp_pkg::bytes_per_word)-1:0] byte_idx_r;
    logic [xfcp_pkg::wb_addr_w-1:0]               addr_r;
    logic [xfcp_pkg::wb_addr_w-1:0]               start_r;
    logic [xfcp_pkg::byte_w-1:0]                  cnt_r;
    logic [xfcp_pkg::byte_w-1:0]                  left_r;
    logic [xfcp_pkg::wb_data_w-1:0]               word_r;
    logic [xfcp_pkg::byte_w-1:0]                  resp_data_r;
    logic [xfcp_pkg::byte_w-1:0]                  resp_byte;
    logic                                          is_wr_r;
    logic                                          op_ok_r;
    logic                                          last_r;
    logic                                          stb_r;
    logic                                          resp_valid_r;
    logic                                          resp_last_r;
    logic                                          resp_last;
    logic                                          resp_load;
    logic                                          resp_free;
    logic                                          req_fire;
    logic                                          known_op;
    logic                                          word_end;

    assign req_tready_o = state_r inside {ST_OP, ST_ADDR, ST_CNT, ST_WDATA, ST_FLUSH};
    assign req_fire     = req_tvalid_i && req_tready_o;
    assign resp_free    = !resp_valid_r || resp_tready_i;
    assign known_op     = req_tdata_i == xfcp_pkg::OP_READ
                          || req_tdata_i == xfcp_pkg::OP_WRITE;
    assign word_end     = int'(byte_idx_r) == xfcp_pkg::bytes_per_word - 1;

    // Next response byte, header fields first, then data LSB first
    always_comb begin
        resp_load = 1'b0;
        resp_byte = word_r[xfcp_pkg::byte_w-1:0];
        resp_last = 1'b0;
        if (state_r == ST_HDR) begin
            resp_load = resp_free;
            case (byte_idx_r)
                2'd0: resp_byte = is_wr_r ? xfcp_pkg::OP_WRITE_RESP : xfcp_pkg::OP_READ_RESP;
                2'd1: resp_byte = start_r;
                default: begin
                    resp_byte = cnt_r;
                    resp_last = is_wr_r || left_r == '0;
                end
            endcase
        end else if (state_r == ST_RDATA) begin
            resp_load = resp_free;
            resp_last = word_end && left_r == '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r      <= ST_OP;
            byte_idx_r   <= '0;
            addr_r       <= '0;
            left_r       <= '0;
            is_wr_r      <= 1'b0;
            op_ok_r      <= 1'b0;
            last_r       <= 1'b0;
            stb_r        <= 1'b0;
            resp_valid_r <= 1'b0;
        end else begin
            if (resp_load) begin
                resp_valid_r <= 1'b1;
            end else if (resp_tready_i) begin
                resp_valid_r <= 1'b0;
            end

            case (state_r)
                ST_OP: begin
                    if (req_fire) begin
                        is_wr_r <= req_tdata_i == xfcp_pkg::OP_WRITE;
                        op_ok_r <= known_op;
                        addr_r  <= '0;
                        left_r  <= '0;
                        if (known_op) begin
                            state_r <= req_tlast_i ? ST_HDR : ST_ADDR;
                        end else begin
                            state_r <= req_tlast_i ? ST_OP : ST_FLUSH;
                        end
                    end
                end
                ST_ADDR: begin
                    if (req_fire) begin
                        addr_r  <= req_tdata_i;
                        state_r <= req_tlast_i ? ST_HDR : ST_CNT;
                    end
                end
                ST_CNT: begin
                    if (req_fire) begin
                        left_r <= req_tdata_i;
                        if (req_tlast_i) begin
                            state_r <= ST_HDR;
                        end else begin
                            state_r <= is_wr_r ? ST_WDATA : ST_FLUSH;
                        end
                    end
                end
                ST_WDATA: begin
                    if (req_fire) begin
                        byte_idx_r <= byte_idx_r + 1'b1;
                        // Only complete words within the count are stored
                        if (word_end && left_r != '0) begin
                            stb_r   <= 1'b1;
                            last_r  <= req_tlast_i;
                            state_r <= ST_WCYC;
                        end else if (req_tlast_i) begin
                            byte_idx_r <= '0;
                            state_r    <= ST_HDR;
                        end
                    end
                end
                ST_WCYC: begin
                    if (wb_ack_i) begin
                        stb_r   <= 1'b0;
                        addr_r  <= addr_r + 1'b1;
                        left_r  <= left_r - 1'b1;
                        state_r <= last_r ? ST_HDR : ST_WDATA;
                    end
                end
                ST_FLUSH: begin
                    if (req_fire && req_tlast_i) begin
                        state_r <= op_ok_r ? ST_HDR : ST_OP;
                    end
                end
                ST_HDR: begin
                    if (resp_load) begin
                        byte_idx_r <= byte_idx_r + 1'b1;
                        if (byte_idx_r == 2'd2) begin
                            byte_idx_r <= '0;
                            if (resp_last) begin
                                state_r <= ST_OP;
                            end else begin
                                stb_r   <= 1'b1;
                                state_r <= ST_RCYC;
                            end
                        end
                    end
                end
                ST_RCYC: begin
                    if (wb_ack_i) begin
                        stb_r   <= 1'b0;
                        addr_r  <= addr_r + 1'b1;
                        left_r  <= left_r - 1'b1;
                        state_r <= ST_RDATA;
                    end
                end
                default: begin
                    if (resp_load) begin
                        byte_idx_r <= byte_idx_r + 1'b1;
                        if (word_end) begin
                            // Next read waits until this word is in the output register
                            if (resp_last) begin
                                state_r <= ST_OP;
                            end else begin
                                stb_r   <= 1'b1;
                                state_r <= ST_RCYC;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_r == ST_OP && req_fire) begin
            start_r <= '0;
            cnt_r   <= '0;
        end else if (state_r == ST_ADDR && req_fire) begin
            start_r <= req_tdata_i;
        end else if (state_r == ST_CNT && req_fire) begin
            cnt_r <= req_tdata_i;
        end
        if (state_r == ST_WDATA && req_fire) begin
            word_r <= {req_tdata_i, word_r[xfcp_pkg::wb_data_w-1:xfcp_pkg::byte_w]};
        end else if (state_r == ST_RCYC && wb_ack_i) begin
            word_r <= wb_dat_i;
        end else if (state_r == ST_RDATA && resp_load) begin
            word_r <= word_r >> xfcp_pkg::byte_w;
        end
        if (resp_load) begin
            resp_data_r <= resp_byte;
            resp_last_r <= resp_last;
        end
    end

    assign resp_tdata_o  = resp_data_r;
    assign resp_tvalid_o = resp_valid_r;
    assign resp_tlast_o  = resp_last_r;

    assign wb_adr_o = addr_r;
    assign wb_dat_o = word_r;
    assign wb_we_o  = is_wr_r;
    assign wb_stb_o = stb_r;
    assign wb_cyc_o = stb_r;

endmodule

//--- src/xfcp_switch.sv
`timescale 1ns/1ps

module xfcp_switch #(
    parameter int PORTS = 3
) (
    input  logic                              clk,
    input  logic                              arst_n_i,

    input  logic [xfcp_pkg::byte_w-1:0]       up_in_tdata_i,
    input  logic                              up_in_tvalid_i,
    output logic                              up_in_tready_o,
    input  logic                              up_in_tlast_i,
    output logic [xfcp_pkg::byte_w-1:0]       up_out_tdata_o,
    output logic                              up_out_tvalid_o,
    input  logic                              up_out_tready_i,
    output logic                              up_out_tlast_o,

    output logic [PORTS*xfcp_pkg::byte_w-1:0] dn_req_tdata_o,
    output logic [PORTS-1:0]                  dn_req_tvalid_o,
    input  logic [PORTS-1:0]                  dn_req_tready_i,
    output logic [PORTS-1:0]                  dn_req_tlast_o,
    input  logic [PORTS*xfcp_pkg::byte_w-1:0] dn_resp_tdata_i,
    input  logic [PORTS-1:0]                  dn_resp_tvalid_i,
    output logic [PORTS-1:0]                  dn_resp_tready_o,
    input  logic [PORTS-1:0]                  dn_resp_tlast_i
);

    typedef enum logic [2:0] {
        SW_IDLE,
        SW_ROUTE,
        SW_DROP,
        SW_PREPEND,
        SW_RETURN
    } state_e;

    state_e                      state_r;
    logic [xfcp_pkg::byte_w-1:0] port_r;
    logic [xfcp_pkg::byte_w-1:0] req_data_r;
    logic [xfcp_pkg::byte_w-1:0] out_data_r;
    logic [xfcp_pkg::byte_w-1:0] lane_tdata;
    logic                        req_valid_r;
    logic                        req_last_r;
    logic                        out_valid_r;
    logic                        out_last_r;
    logic                        first_r;
    logic                        resp_exp_r;
    logic [PORTS-1:0]            lane_sel;
    logic                        lane_tvalid;
    logic                        lane_tlast;
    logic                        lane_ready;
    logic                        req_ready;
    logic                        in_fire;
    logic                        out_free;
    logic                        out_load;
    logic                        known_op;
    logic                        expect_resp;

    // Lane selected by the stored port byte
    always_comb begin
        lane_sel    = '0;
        lane_tdata  = '0;
        lane_tvalid = 1'b0;
        lane_tlast  = 1'b0;
        for (int i = 0; i < PORTS; i++) begin
            if (int'(port_r) == i) begin
                lane_sel[i] = 1'b1;
                lane_tdata  = dn_resp_tdata_i[i*xfcp_pkg::byte_w +: xfcp_pkg::byte_w];
                lane_tvalid = dn_resp_tvalid_i[i];
                lane_tlast  = dn_resp_tlast_i[i];
            end
        end
    end

    always_comb begin
        case (state_r)
            SW_IDLE:  up_in_tready_o = !req_valid_r;
            SW_ROUTE: up_in_tready_o = !req_valid_r || req_ready;
            SW_DROP:  up_in_tready_o = 1'b1;
            default:  up_in_tready_o = 1'b0;
        endcase
    end

    assign req_ready  = |(dn_req_tready_i & lane_sel);
    assign in_fire    = up_in_tvalid_i && up_in_tready_o;
    assign known_op   = up_in_tdata_i == xfcp_pkg::OP_READ
                        || up_in_tdata_i == xfcp_pkg::OP_WRITE;
    // Only a known opcode gets an answer from the endpoint
    assign expect_resp = first_r ? known_op : resp_exp_r;

    // Hold off further response bytes once tlast sits in the output register
    assign out_free   = !out_valid_r || up_out_tready_i;
    assign lane_ready = state_r == SW_RETURN
                        && (!out_valid_r || (up_out_tready_i && !out_last_r));
    assign out_load   = (state_r == SW_PREPEND && out_free) || (lane_tvalid && lane_ready);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r     <= SW_IDLE;
            port_r      <= '0;
            req_valid_r <= 1'b0;
            out_valid_r <= 1'b0;
            first_r     <= 1'b0;
            resp_exp_r  <= 1'b0;
        end else begin
            if (state_r == SW_ROUTE && in_fire) begin
                req_valid_r <= 1'b1;
            end else if (req_ready) begin
                req_valid_r <= 1'b0;
            end
            if (out_load) begin
                out_valid_r <= 1'b1;
            end else if (up_out_tready_i) begin
                out_valid_r <= 1'b0;
            end

            case (state_r)
                SW_IDLE: begin
                    if (in_fire) begin
                        port_r  <= up_in_tdata_i;
                        first_r <= 1'b1;
                        if (up_in_tlast_i) begin
                            state_r <= SW_IDLE;
                        end else if (int'(up_in_tdata_i) < PORTS) begin
                            state_r <= SW_ROUTE;
                        end else begin
                            state_r <= SW_DROP;
                        end
                    end
                end
                SW_ROUTE: begin
                    if (in_fire) begin
                        first_r <= 1'b0;
                        if (first_r) begin
                            resp_exp_r <= known_op;
                        end
                        if (up_in_tlast_i) begin
                            state_r <= expect_resp ? SW_PREPEND : SW_IDLE;
                        end
                    end
                end
                SW_DROP: begin
                    if (in_fire && up_in_tlast_i) begin
                        state_r <= SW_IDLE;
                    end
                end
                SW_PREPEND: begin
                    if (out_free) begin
                        state_r <= SW_RETURN;
                    end
                end
                default: begin
                    if (out_valid_r && up_out_tready_i && out_last_r) begin
                        state_r <= SW_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_r == SW_ROUTE && in_fire) begin
            req_data_r <= up_in_tdata_i;
            req_last_r <= up_in_tlast_i;
        end
        if (state_r == SW_PREPEND) begin
            out_data_r <= port_r;
            out_last_r <= 1'b0;
        end else if (out_load) begin
            out_data_r <= lane_tdata;
            out_last_r <= lane_tlast;
        end
    end

    assign dn_req_tdata_o   = {PORTS{req_data_r}};
    assign dn_req_tlast_o   = {PORTS{req_last_r}};
    assign dn_req_tvalid_o  = lane_sel & {PORTS{req_valid_r}};
    assign dn_resp_tready_o = lane_sel & {PORTS{lane_ready}};

    assign up_out_tdata_o  = out_data_r;
    assign up_out_tvalid_o = out_valid_r;
    assign up_out_tlast_o  = out_last_r;

endmodule

//--- src/xfcp_core.sv
`timescale 1ns/1ps

module xfcp_core #(
    parameter int PORTS = 3
) (
    input  logic                        clk,
    input  logic                        arst_n_i,

    input  logic [xfcp_pkg::byte_w-1:0] up_in_tdata_i,
    input  logic                        up_in_tvalid_i,
    output logic                        up_in_tready_o,
    input  logic                        up_in_tlast_i,

    output logic [xfcp_pkg::byte_w-1:0] up_out_tdata_o,
    output logic                        up_out_tvalid_o,
    input  logic                        up_out_tready_i,
    output logic                        up_out_tlast_o
);

    // Per-port streams, one byte lane per endpoint
    logic [PORTS*xfcp_pkg::byte_w-1:0] dn_in_tdata;
    logic [PORTS-1:0]                  dn_in_tvalid;
    logic [PORTS-1:0]                  dn_in_tready;
    logic [PORTS-1:0]                  dn_in_tlast;
    logic [PORTS*xfcp_pkg::byte_w-1:0] dn_out_tdata;
    logic [PORTS-1:0]                  dn_out_tvalid;
    logic [PORTS-1:0]                  dn_out_tready;
    logic [PORTS-1:0]                  dn_out_tlast;

    xfcp_switch #(
        .PORTS(PORTS)
    ) switch_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .up_in_tdata_i(up_in_tdata_i),
        .up_in_tvalid_i(up_in_tvalid_i),
        .up_in_tready_o(up_in_tready_o),
        .up_in_tlast_i(up_in_tlast_i),
        .up_out_tdata_o(up_out_tdata_o),
        .up_out_tvalid_o(up_out_tvalid_o),
        .up_out_tready_i(up_out_tready_i),
        .up_out_tlast_o(up_out_tlast_o),
        .dn_req_tdata_o(dn_in_tdata),
        .dn_req_tvalid_o(dn_in_tvalid),
        .dn_req_tready_i(dn_in_tready),
        .dn_req_tlast_o(dn_in_tlast),
        .dn_resp_tdata_i(dn_out_tdata),
        .dn_resp_tvalid_i(dn_out_tvalid),
        .dn_resp_tready_o(dn_out_tready),
        .dn_resp_tlast_i(dn_out_tlast)
    );

    for (genvar i = 0; i < PORTS; i++) begin : g_port
        logic [xfcp_pkg::wb_addr_w-1:0] wb_adr;
        logic [xfcp_pkg::wb_data_w-1:0] wb_dat_w;
        logic [xfcp_pkg::wb_data_w-1:0] wb_dat_r;
        logic                           wb_we;
        logic                           wb_stb;
        logic                           wb_cyc;
        logic                           wb_ack;

        xfcp_mod_wb mod_wb_inst (
            .clk(clk),
            .arst_n_i(arst_n_i),
            .req_tdata_i(dn_in_tdata[i*xfcp_pkg::byte_w +: xfcp_pkg::byte_w]),
            .req_tvalid_i(dn_in_tvalid[i]),
            .req_tready_o(dn_in_tready[i]),
            .req_tlast_i(dn_in_tlast[i]),
            .resp_tdata_o(dn_out_tdata[i*xfcp_pkg::byte_w +: xfcp_pkg::byte_w]),
            .resp_tvalid_o(dn_out_tvalid[i]),
            .resp_tready_i(dn_out_tready[i]),
            .resp_tlast_o(dn_out_tlast[i]),
            .wb_adr_o(wb_adr),
            .wb_dat_o(wb_dat_w),
            .wb_dat_i(wb_dat_r),
            .wb_we_o(wb_we),
            .wb_stb_o(wb_stb),
            .wb_cyc_o(wb_cyc),
            .wb_ack_i(wb_ack)
        );

        wb_ram ram_inst (
            .clk(clk),
            .arst_n_i(arst_n_i),
            .adr_i(wb_adr),
            .dat_i(wb_dat_w),
            .dat_o(wb_dat_r),
            .we_i(wb_we),
            .stb_i(wb_stb),
            .cyc_i(wb_cyc),
            .ack_o(wb_ack)
        );
    end

endmodule

//--- test/xfcp_core_chk.sv
`timescale 1ns/1ps

module xfcp_core_chk (
    input logic                        clk,
    input logic                        arst_n_i,
    input logic [xfcp_pkg::byte_w-1:0] resp_tdata_i,
    input logic                        resp_tvalid_i,
    input logic                        resp_tready_i,
    input logic                        resp_tlast_i,
    input logic                        wb_stb_i,
    input logic                        wb_cyc_i,
    input logic                        wb_ack_i
);

    // Stalled response byte stays put
    a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        resp_tvalid_i && !resp_tready_i
        |=> resp_tvalid_i && $stable(resp_tdata_i) && $stable(resp_tlast_i))
        else $error("response stream changed while stalled");

    // Slave answers only inside an active cycle
    a_ack_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_i |-> wb_cyc_i && wb_stb_i)
        else $error("wishbone ack outside a cycle");

    // Strobe held until the slave answers
    a_stb_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_stb_i && !wb_ack_i |=> wb_stb_i)
        else $error("wishbone stb dropped before ack");

    a_ack_delay: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(wb_stb_i) |-> !wb_ack_i ##1 wb_ack_i)
        else $error("wishbone ack not one cycle after stb");

endmodule

//--- test/tb_xfcp_core.sv
`timescale 1ns/1ps

module tb_xfcp_core;

    localparam int PORTS = 3;
    localparam int N_CMD = 13;
    localparam logic [31:0] SEED = 32'hdb89794d;

    typedef struct packed {
        logic [7:0] port;
        logic [7:0] op;
        logic [7:0] addr;
        logic [7:0] cnt;
        logic       bp;
    } cmd_t;

    // Port, opcode, start address, word count, random back-pressure
    cmd_t cmd_tab [0:N_CMD-1] = '{
        '{8'd0, xfcp_pkg::OP_WRITE, 8'h00, 8'd8, 1'b0},
        '{8'd1, xfcp_pkg::OP_WRITE, 8'h00, 8'd8, 1'b0},
        '{8'd0, xfcp_pkg::OP_READ,  8'h00, 8'd8, 1'b0},
        '{8'd1, xfcp_pkg::OP_READ,  8'h00, 8'd8, 1'b0},
        '{8'd2, xfcp_pkg::OP_WRITE, 8'hfd, 8'd6, 1'b0},
        '{8'd2, xfcp_pkg::OP_READ,  8'hfd, 8'd6, 1'b0},
        '{8'd5, xfcp_pkg::OP_WRITE, 8'h10, 8'd2, 1'b0},
        '{8'd1, 8'h55,              8'h00, 8'd1, 1'b0},
        '{8'd0, xfcp_pkg::OP_READ,  8'h02, 8'd4, 1'b0},
        '{8'd0, xfcp_pkg::OP_READ,  8'h00, 8'd8, 1'b1},
        '{8'd2, xfcp_pkg::OP_READ,  8'hfd, 8'd6, 1'b1},
        '{8'd1, xfcp_pkg::OP_WRITE, 8'h04, 8'd3, 1'b1},
        '{8'd1, xfcp_pkg::OP_READ,  8'h00, 8'd8, 1'b1}
    };

    logic       clk;
    logic       arst_n_i;
    logic [7:0] up_in_tdata_i;
    logic       up_in_tvalid_i;
    logic       up_in_tready_o;
    logic       up_in_tlast_i;
    logic [7:0] up_out_tdata_o;
    logic       up_out_tvalid_o;
    logic       up_out_tready_i;
    logic       up_out_tlast_o;

    logic        bp_en;
    logic [31:0] data_lfsr = SEED;
    logic [31:0] bp_lfsr = SEED;
    logic [31:0] ref_mem [0:PORTS-1][0:255];
    logic [7:0]  req_q [$];
    // Response bytes as {tlast, tdata}
    logic [8:0]  exp_q [$];
    logic [8:0]  rx_q [$];

    xfcp_core #(
        .PORTS(PORTS)
    ) dut0 (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .up_in_tdata_i(up_in_tdata_i),
        .up_in_tvalid_i(up_in_tvalid_i),
        .up_in_tready_o(up_in_tready_o),
        .up_in_tlast_i(up_in_tlast_i),
        .up_out_tdata_o(up_out_tdata_o),
        .up_out_tvalid_o(up_out_tvalid_o),
        .up_out_tready_i(up_out_tready_i),
        .up_out_tlast_o(up_out_tlast_o)
    );

    bind xfcp_mod_wb xfcp_core_chk chk0 (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .resp_tdata_i(resp_tdata_o),
        .resp_tvalid_i(resp_tvalid_o),
        .resp_tready_i(resp_tready_i),
        .resp_tlast_i(resp_tlast_o),
        .wb_stb_i(wb_stb_o),
        .wb_cyc_i(wb_cyc_o),
        .wb_ack_i(wb_ack_i)
    );

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic int total_bytes();
        int n;
        n = 0;
        for (int i = 0; i < N_CMD; i++) begin
            n += 8 + 4 * int'(cmd_tab[i].cnt);
        end
        return n;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic next_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            data_lfsr = lfsr_step(data_lfsr);
            w[b] = data_lfsr[0];
        end
    endtask

    // Request bytes, expected response and reference memory update
    task automatic build_cmd(input cmd_t c);
        logic [31:0] w;
        logic [7:0]  a;
        logic [8:0]  e;
        logic        answered;
        req_q.delete();
        exp_q.delete();
        answered = int'(c.port) < PORTS
                   && (c.op == xfcp_pkg::OP_READ || c.op == xfcp_pkg::OP_WRITE);
        req_q.push_back(c.port);
        req_q.push_back(c.op);
        req_q.push_back(c.addr);
        req_q.push_back(c.cnt);
        if (answered) begin
            exp_q.push_back({1'b0, c.port});
            if (c.op == xfcp_pkg::OP_WRITE) begin
                exp_q.push_back({1'b0, 8'(xfcp_pkg::OP_WRITE_RESP)});
            end else begin
                exp_q.push_back({1'b0, 8'(xfcp_pkg::OP_READ_RESP)});
            end
            exp_q.push_back({1'b0, c.addr});
            exp_q.push_back({1'b0, c.cnt});
        end
        for (int i = 0; i < int'(c.cnt); i++) begin
            // Address wraps modulo 256
            a = c.addr + 8'(i);
            if (c.op == xfcp_pkg::OP_WRITE) begin
                next_word(w);
                for (int b = 0; b < 4; b++) begin
                    req_q.push_back(w[8*b +: 8]);
                end
                if (answered) begin
                    ref_mem[c.port][a] = w;
                end
            end else if (answered) begin
                for (int b = 0; b < 4; b++) begin
                    exp_q.push_back({1'b0, ref_mem[c.port][a][8*b +: 8]});
                end
            end
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_back();
            e[8] = 1'b1;
            exp_q.push_back(e);
        end
    endtask

    // Called just after a rising edge
    task automatic send_req();
        logic ok;
        for (int i = 0; i < req_q.size(); i++) begin
            up_in_tdata_i  = req_q[i];
            up_in_tvalid_i = 1'b1;
            up_in_tlast_i  = i == req_q.size() - 1;
            do begin
                @(negedge clk);
                ok = up_in_tready_o;
                @(posedge clk);
                #1;
            end while (!ok);
        end
        up_in_tvalid_i = 1'b0;
        up_in_tlast_i  = 1'b0;
    endtask

    task automatic check_resp();
        logic [8:0] got;
        logic [8:0] exp;
        while (rx_q.size() < exp_q.size()) begin
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < exp_q.size(); k++) begin
            got = rx_q.pop_front();
            exp = exp_q[k];
            assert (got[7:0] == exp[7:0]) else report_failure($sformatf(
                "mismatch up_out_tdata_o byte %0d: got %h expected %h", k, got[7:0], exp[7:0]));
            assert (got[8] == exp[8]) else report_failure($sformatf(
                "mismatch up_out_tlast_o byte %0d: got %h expected %h", k, got[8], exp[8]));
        end
        if (exp_q.size() == 0) begin
            // A dropped request stays silent
            repeat (20) @(posedge clk);
            #1;
            assert (rx_q.size() == 0) else report_failure(
                "response bytes arrived for a request that should get none");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Response bytes that complete on the next rising edge
    always @(negedge clk) begin
        if (up_out_tvalid_o && up_out_tready_i) begin
            rx_q.push_back({up_out_tlast_o, up_out_tdata_o});
        end
    end

    initial begin
        logic en;
        forever begin
            @(posedge clk);
            en = bp_en;
            #1;
            if (en) begin
                bp_lfsr = lfsr_step(bp_lfsr);
                up_out_tready_i = bp_lfsr[0];
            end else begin
                up_out_tready_i = 1'b1;
            end
        end
    end

    initial begin
        int limit;
        limit = total_bytes() * 40 + 1000;
        repeat (limit) @(posedge clk);
        report_failure("timeout: the response did not arrive in time");
    end

    initial begin
        arst_n_i        = 1'b0;
        up_in_tdata_i   = '0;
        up_in_tvalid_i  = 1'b0;
        up_in_tlast_i   = 1'b0;
        up_out_tready_i = 1'b1;
        bp_en           = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < N_CMD; i++) begin
            build_cmd(cmd_tab[i]);
            bp_en = cmd_tab[i].bp;
            send_req();
            check_resp();
        end
        repeat (20) @(posedge clk);
        assert (rx_q.size() == 0) else report_failure(
            "extra response bytes arrived after the last command");
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- sim.f
src/xfcp_pkg.sv
src/wb_ram.sv
src/xfcp_mod_wb.sv
src/xfcp_switch.sv
src/xfcp_core.sv
test/xfcp_core_chk.sv
test/tb_xfcp_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_xfcp_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
